/* hdl/dmacPkg.sv */
// Shared types for the SCSI read DMA. Only the peripheral-to-memory direction exists and words are big-endian
package dmacPkg;

    typedef logic [7:0]  byte_t;     // Peripheral data byte
    typedef logic [31:0] word_t;     // Memory data word
    typedef logic [31:0] addr_t;     // Byte address, writes are word aligned
    typedef logic [15:0] count_t;    // Transfer length in bytes
    typedef logic [1:0]  regAddr_t;  // CPU register select

    // Register map
    localparam regAddr_t regAddrSel  = 2'd0;  // Start address
    localparam regAddr_t regCountSel = 2'd1;  // Byte count
    localparam regAddr_t regCtrlSel  = 2'd2;  // Bit 0 start, bit 1 interrupt enable
    localparam regAddr_t regStatSel  = 2'd3;  // Bit 0 done, bit 1 busy

    // One CPU register access
    typedef struct packed {
        logic     we;
        regAddr_t addr;
        word_t    wdata;
    } cpuReq_t;

    // One memory word write
    typedef struct packed {
        addr_t addr;
        word_t data;
    } memReq_t;

    // Peripheral side FSM
    typedef enum logic [1:0] {
        PIdle,
        PWait,   // Bytes remain, waiting for dreq
        PAck,    // dack high until dreq drops
        PFlush   // Last byte taken
    } periphState_t;

    // Bus side FSM
    typedef enum logic [1:0] {
        BIdle,
        BReq,      // memReq high, waiting for memAck
        BRelease,  // Waiting for memAck to drop
        BNext      // Pop and address step
    } busState_t;

endpackage

/* hdl/dmacRegisters.sv */
// Register access completes one cycle after regReq is seen and a status read clears done and int
`timescale 1ns/1ps

module dmacRegisters (
    input  logic             nSCLK,
    input  logic             nAS_,
    input  dmacPkg::cpuReq_t cpuReq_i,
    input  logic             regReq_i,
    output logic             regAck_o,
    output dmacPkg::word_t   regRdata_o,
    input  logic             xferDone_i,
    output logic             startPulse_o,
    output dmacPkg::addr_t   startAddr_o,
    output dmacPkg::count_t  byteCount_o,
    output logic             int_o
);
    import dmacPkg::*;

    logic  accept;     // First cycle of a new request
    logic  startArm;   // Start bit written, pulse follows
    logic  intEnable;
    logic  doneBit;
    logic  busyBit;
    word_t readMux;

    assign accept = regReq_i && !regAck_o;
    assign int_o  = doneBit && intEnable;

    always_comb begin
        case (cpuReq_i.addr)
            regAddrSel:  readMux = startAddr_o;
            regCountSel: readMux = {16'b0, byteCount_o};
            regCtrlSel:  readMux = {30'b0, intEnable, 1'b0};
            default:     readMux = {30'b0, busyBit, doneBit};
        endcase
    end

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            regAck_o     <= 1'b0;
            startArm     <= 1'b0;
            startPulse_o <= 1'b0;
            startAddr_o  <= '0;
            byteCount_o  <= '0;
            intEnable    <= 1'b0;
            doneBit      <= 1'b0;
            busyBit      <= 1'b0;
        end else begin
            regAck_o     <= regReq_i;  // Ack follows req by one cycle both ways
            startArm     <= 1'b0;
            startPulse_o <= startArm;
            if (accept && cpuReq_i.we) begin
                case (cpuReq_i.addr)
                    regAddrSel:  startAddr_o <= cpuReq_i.wdata;
                    regCountSel: byteCount_o <= cpuReq_i.wdata[15:0];
                    regCtrlSel: begin
                        intEnable <= cpuReq_i.wdata[1];
                        startArm  <= cpuReq_i.wdata[0];
                    end
                    default: ;  // Status is read only
                endcase
            end
            if (accept && !cpuReq_i.we && cpuReq_i.addr == regStatSel)
                doneBit <= 1'b0;
            if (startArm) begin
                busyBit <= 1'b1;
                doneBit <= 1'b0;
            end
            // End of transfer wins over a read clear in the same cycle
            if (xferDone_i) begin
                busyBit <= 1'b0;
                doneBit <= 1'b1;
            end
        end
    end

    always_ff @(posedge nSCLK) begin
        if (accept)
            regRdata_o <= readMux;  // Sampled before a read clear lands
    end

    // Requester withdraws only once the ack is up
    reqHeldForAck: assert property (@(posedge nSCLK) disable iff (!nAS_)
        $fell(regReq_i) |-> regAck_o);

endmodule

/* hdl/periphPort.sv */
// Peripheral handshake is four-phase dreq/dack and dack waits while the FIFO reports full
`timescale 1ns/1ps

module periphPort (
    input  logic            nSCLK,
    input  logic            nAS_,
    input  logic            startPulse_i,
    input  dmacPkg::count_t byteCount_i,
    input  logic            dreq_i,
    output logic            dack_o,
    input  dmacPkg::byte_t  pData_i,
    input  logic            fifoFull_i,
    input  logic            partialPending_i,
    output logic            pushByte_o,
    output dmacPkg::byte_t  pushData_o,
    output logic            flushReq_o,
    output logic            periphDone_o
);
    import dmacPkg::*;

    periphState_t state;
    count_t       remaining;
    logic         takeByte;

    assign takeByte = (state == PWait) && dreq_i && !fifoFull_i;

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            state        <= PIdle;
            remaining    <= '0;
            dack_o       <= 1'b0;
            pushByte_o   <= 1'b0;
            flushReq_o   <= 1'b0;
            periphDone_o <= 1'b0;
        end else begin
            pushByte_o <= 1'b0;
            flushReq_o <= 1'b0;
            if (startPulse_i) begin
                remaining    <= byteCount_i;
                dack_o       <= 1'b0;
                periphDone_o <= (byteCount_i == '0);  // Empty transfer is done at once
                state        <= (byteCount_i == '0) ? PIdle : PWait;
            end else begin
                case (state)
                    PWait: if (takeByte) begin
                        dack_o     <= 1'b1;
                        pushByte_o <= 1'b1;
                        remaining  <= remaining - count_t'(1);
                        state      <= PAck;
                    end
                    PAck: if (!dreq_i) begin
                        dack_o <= 1'b0;
                        state  <= (remaining == '0) ? PFlush : PWait;
                    end
                    PFlush: begin
                        flushReq_o   <= partialPending_i;  // Only a partial word needs it
                        periphDone_o <= 1'b1;
                        state        <= PIdle;
                    end
                    default: ;  // Idle or done, dreq ignored
                endcase
            end
        end
    end

    always_ff @(posedge nSCLK) begin
        if (takeByte)
            pushData_o <= pData_i;
    end

    // Device keeps dreq up until it sees dack
    dreqHeldForDack: assert property (@(posedge nSCLK) disable iff (!nAS_)
        $fell(dreq_i) |-> dack_o);

endmodule

/* hdl/wordFifo.sv */
// Byte packer and word FIFO. fifoDepth must be a power of two and at least 2
`timescale 1ns/1ps

module wordFifo #(
    parameter int fifoDepth = 4
) (
    input  logic           nSCLK,
    input  logic           nAS_,
    input  logic           startPulse_i,
    input  logic           pushByte_i,
    input  dmacPkg::byte_t pushData_i,
    input  logic           flushReq_i,
    input  logic           popWord_i,
    output dmacPkg::word_t headWord_o,
    output logic           fifoFull_o,
    output logic           fifoEmpty_o,
    output logic           partialPending_o
);
    import dmacPkg::*;

    localparam int ptrW = $clog2(fifoDepth);
    localparam logic [ptrW:0] depthCount = (ptrW + 1)'(fifoDepth);

    word_t           mem [fifoDepth];
    word_t           packReg;     // Word being assembled
    logic [1:0]      offset;      // Next byte lane, 0 is bits 31 to 24
    logic            commitPend;  // packReg enters the FIFO at the next edge
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [ptrW:0]   count;

    assign headWord_o       = mem[rdPtr];
    assign fifoEmpty_o      = (count == '0);
    assign partialPending_o = (offset != 2'd0) || commitPend;
    // A pending commit already owns a slot
    assign fifoFull_o = (count == depthCount) || (commitPend && count == depthCount - 1'b1);

    always_ff @(posedge nSCLK) begin
        if (pushByte_i) begin
            if (offset == 2'd0)
                packReg <= {pushData_i, 24'b0};  // Fresh word, low lanes zero padded
            else
                packReg[{~offset, 3'b000} +: 8] <= pushData_i;
        end
        if (commitPend)
            mem[wrPtr] <= packReg;
    end

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            offset     <= 2'd0;
            commitPend <= 1'b0;
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
        end else if (startPulse_i) begin
            offset     <= 2'd0;
            commitPend <= 1'b0;
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
        end else begin
            commitPend <= (pushByte_i && offset == 2'd3) || (flushReq_i && offset != 2'd0);
            if (pushByte_i)
                offset <= offset + 2'd1;
            else if (flushReq_i)
                offset <= 2'd0;
            if (commitPend)
                wrPtr <= wrPtr + 1'b1;
            if (popWord_i)
                rdPtr <= rdPtr + 1'b1;
            case ({commitPend, popWord_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

    noOverUnderRun: assert property (@(posedge nSCLK) disable iff (!nAS_)
        !(commitPend && count == depthCount) && !(popWord_i && fifoEmpty_o));

endmodule

/* hdl/busMaster.sv */
// One four-phase word write per FIFO word and the start address is forced to word alignment
`timescale 1ns/1ps

module busMaster (
    input  logic             nSCLK,
    input  logic             nAS_,
    input  logic             startPulse_i,
    input  dmacPkg::addr_t   startAddr_i,
    input  logic             fifoEmpty_i,
    input  dmacPkg::word_t   headWord_i,
    input  logic             periphDone_i,
    input  logic             partialPending_i,
    output logic             memReq_o,
    input  logic             memAck_i,
    output dmacPkg::memReq_t mem_o,
    output logic             popWord_o,
    output logic             xferDone_o
);
    import dmacPkg::*;

    busState_t state;
    addr_t     addrReg;
    logic      active;  // Started and not yet reported done
    logic      launch;

    assign launch    = (state == BIdle) && !fifoEmpty_i;
    assign popWord_o = (state == BNext);

    always_ff @(posedge nSCLK or negedge nAS_) begin
        if (!nAS_) begin
            state      <= BIdle;
            addrReg    <= '0;
            active     <= 1'b0;
            memReq_o   <= 1'b0;
            xferDone_o <= 1'b0;
        end else begin
            xferDone_o <= 1'b0;
            case (state)
                BIdle: begin
                    if (launch) begin
                        memReq_o <= 1'b1;
                        state    <= BReq;
                    end else if (active && periphDone_i && !partialPending_i) begin
                        xferDone_o <= 1'b1;  // Nothing left anywhere in the path
                        active     <= 1'b0;
                    end
                end
                BReq: if (memAck_i) begin
                    memReq_o <= 1'b0;
                    state    <= BRelease;
                end
                BRelease: if (!memAck_i) begin
                    addrReg <= addrReg + addr_t'(4);
                    state   <= BNext;
                end
                default: state <= BIdle;  // BNext, pop happens this cycle
            endcase
            // Start overrides any address step
            if (startPulse_i) begin
                addrReg <= {startAddr_i[31:2], 2'b00};
                active  <= 1'b1;
            end
        end
    end

    always_ff @(posedge nSCLK) begin
        if (launch) begin
            mem_o.addr <= addrReg;
            mem_o.data <= headWord_i;
        end
    end

    memStableInReq: assert property (@(posedge nSCLK) disable iff (!nAS_)
        memReq_o && $past(memReq_o) |-> $stable(mem_o));

endmodule

/* hdl/sdmacTop.sv */
// SCSI read DMA top with peripheral to memory only and no bus arbitration or bus sizing
`timescale 1ns/1ps

module sdmacTop #(
    parameter int fifoDepth = 4  // Power of two, at least 2
) (
    input  logic             nSCLK,
    input  logic             nAS_,
    input  dmacPkg::cpuReq_t cpuReq_i,
    input  logic             regReq_i,
    output logic             regAck_o,
    output dmacPkg::word_t   regRdata_o,
    input  logic             dreq_i,
    output logic             dack_o,
    input  dmacPkg::byte_t   pData_i,
    output logic             memReq_o,
    input  logic             memAck_i,
    output dmacPkg::memReq_t mem_o,
    output logic             int_o
);
    import dmacPkg::*;

    logic   startPulse;
    addr_t  startAddr;
    count_t byteCount;
    logic   xferDone;
    logic   pushByte;
    byte_t  pushData;
    logic   flushReq;
    logic   periphDone;
    logic   fifoFull;
    logic   fifoEmpty;
    word_t  headWord;
    logic   partialPending;
    logic   popWord;

    dmacRegisters iRegisters (
        .nSCLK        (nSCLK),
        .nAS_         (nAS_),
        .cpuReq_i     (cpuReq_i),
        .regReq_i     (regReq_i),
        .regAck_o     (regAck_o),
        .regRdata_o   (regRdata_o),
        .xferDone_i   (xferDone),
        .startPulse_o (startPulse),
        .startAddr_o  (startAddr),
        .byteCount_o  (byteCount),
        .int_o        (int_o)
    );

    periphPort iPeriphPort (
        .nSCLK            (nSCLK),
        .nAS_             (nAS_),
        .startPulse_i     (startPulse),
        .byteCount_i      (byteCount),
        .dreq_i           (dreq_i),
        .dack_o           (dack_o),
        .pData_i          (pData_i),
        .fifoFull_i       (fifoFull),
        .partialPending_i (partialPending),
        .pushByte_o       (pushByte),
        .pushData_o       (pushData),
        .flushReq_o       (flushReq),
        .periphDone_o     (periphDone)
    );

    wordFifo #(
        .fifoDepth (fifoDepth)
    ) iWordFifo (
        .nSCLK            (nSCLK),
        .nAS_             (nAS_),
        .startPulse_i     (startPulse),
        .pushByte_i       (pushByte),
        .pushData_i       (pushData),
        .flushReq_i       (flushReq),
        .popWord_i        (popWord),
        .headWord_o       (headWord),
        .fifoFull_o       (fifoFull),
        .fifoEmpty_o      (fifoEmpty),
        .partialPending_o (partialPending)
    );

    busMaster iBusMaster (
        .nSCLK            (nSCLK),
        .nAS_             (nAS_),
        .startPulse_i     (startPulse),
        .startAddr_i      (startAddr),
        .fifoEmpty_i      (fifoEmpty),
        .headWord_i       (headWord),
        .periphDone_i     (periphDone),
        .partialPending_i (partialPending),
        .memReq_o         (memReq_o),
        .memAck_i         (memAck_i),
        .mem_o            (mem_o),
        .popWord_o        (popWord),
        .xferDone_o       (xferDone)
    );

endmodule

/* sim/sdmacTb.sv */
// Runs with fifoDepth 4, random memory ack delays and dreq gaps, and byte data from a fixed seed
`timescale 1ns/1ps

module sdmacTb;
    import dmacPkg::*;

    typedef byte_t   byteQ_t[$];
    typedef memReq_t memQ_t[$];

    localparam int totalBytes  = 16 + 7 + 40;
    localparam int limitCycles = totalBytes * 40 + 2000;

    logic    nSCLK;
    logic    nAS_;
    cpuReq_t cpuReq;
    logic    regReq;
    logic    regAck;
    word_t   regRdata;
    logic    dreq;
    logic    dack;
    byte_t   pData;
    logic    memReq;
    logic    memAck;
    memReq_t memBus;
    logic    intLine;

    string   testName;
    memQ_t   expected;     // All writes expected so far, in order
    memQ_t   writeLog;     // Writes seen by the memory model
    int      compared = 0;
    int      maxMemDelay;
    int      maxGap;
    logic    dackPrev;
    logic    dreqPrev;
    word_t   lastData;
    word_t   rd;

    sdmacTop #(.fifoDepth(4)) i_sdmacTop (
        .nSCLK(nSCLK), .nAS_(nAS_), .cpuReq_i(cpuReq), .regReq_i(regReq),
        .regAck_o(regAck), .regRdata_o(regRdata), .dreq_i(dreq), .dack_o(dack),
        .pData_i(pData), .memReq_o(memReq), .memAck_i(memAck), .mem_o(memBus),
        .int_o(intLine)
    );

    initial begin
        nSCLK = 1'b0;
        forever #5 nSCLK = ~nSCLK;
    end

    task automatic checkVal(input string what, input logic [63:0] expVal,
                            input logic [63:0] actVal);
        if (expVal !== actVal) begin
            $display("** Error %s: %s expected %0h, actual %0h", testName, what, expVal, actVal);
            $display("** FAIL **");
            $fatal(1, "Mismatch");
        end
    endtask

    // Big-endian packing, first byte in bits 31 to 24, unfilled lanes zero
    function automatic memQ_t packWords(input byteQ_t bytes, input addr_t base);
        memQ_t   words;
        memReq_t entry;
        int      i;
        int      lane;
        entry = '0;
        for (i = 0; i < bytes.size(); i++) begin
            lane = i % 4;
            if (lane == 0) begin
                entry.addr = base + addr_t'(4 * (i / 4));
                entry.data = '0;
            end
            entry.data[31 - 8 * lane -: 8] = bytes[i];
            if (lane == 3 || i == bytes.size() - 1)
                words.push_back(entry);
        end
        return words;
    endfunction

    task automatic regAccess(input logic we, input regAddr_t addr, input word_t data,
                             output word_t rdata);
        @(negedge nSCLK);
        cpuReq.we    = we;
        cpuReq.addr  = addr;
        cpuReq.wdata = data;
        regReq       = 1'b1;
        @(negedge nSCLK);
        while (!regAck) @(negedge nSCLK);
        rdata  = regRdata;
        regReq = 1'b0;
        @(negedge nSCLK);
        while (regAck) @(negedge nSCLK);
    endtask

    task automatic sendBytes(input byteQ_t bytes);
        foreach (bytes[i]) begin
            @(negedge nSCLK);
            pData = bytes[i];
            dreq  = 1'b1;
            @(negedge nSCLK);
            while (!dack) @(negedge nSCLK);  // Stalls here under back-pressure
            dreq = 1'b0;
            @(negedge nSCLK);
            while (dack) @(negedge nSCLK);
            repeat ($urandom_range(maxGap, 0)) @(negedge nSCLK);
        end
    endtask

    task automatic runTransfer(input string name, input addr_t base, input int nBytes,
                               input logic intEn);
        byteQ_t bytes;
        memQ_t  words;
        word_t  status;
        testName = name;
        repeat (nBytes) bytes.push_back(byte_t'($urandom));
        words = packWords(bytes, base);
        foreach (words[i]) expected.push_back(words[i]);
        regAccess(1'b1, regAddrSel, base, status);
        regAccess(1'b1, regCountSel, word_t'(nBytes), status);
        regAccess(1'b1, regCtrlSel, {30'b0, intEn, 1'b1}, status);
        sendBytes(bytes);
        while (compared < expected.size()) @(negedge nSCLK);
        if (intEn) begin
            while (!intLine) @(negedge nSCLK);
            regAccess(1'b0, regStatSel, '0, status);
            checkVal("status at end", 64'h1, 64'(status[1:0]));
            checkVal("int after status read", 64'h0, 64'(intLine));
        end else begin
            status = 32'h2;
            while (status[1]) begin
                checkVal("int with enable off", 64'h0, 64'(intLine));
                regAccess(1'b0, regStatSel, '0, status);
            end
            checkVal("status at end", 64'h1, 64'(status[1:0]));
        end
        regAccess(1'b0, regStatSel, '0, status);
        checkVal("status after clear", 64'h0, 64'(status[1:0]));
        checkVal("int after clear", 64'h0, 64'(intLine));
    endtask

    // Memory model
    initial begin
        memAck = 1'b0;
        forever begin
            @(negedge nSCLK);
            if (memReq) begin
                writeLog.push_back(memBus);
                repeat ($urandom_range(maxMemDelay, 0)) @(negedge nSCLK);
                memAck = 1'b1;
                @(negedge nSCLK);
                while (memReq) @(negedge nSCLK);
                repeat ($urandom_range(maxMemDelay, 0)) @(negedge nSCLK);
                memAck = 1'b0;
            end
        end
    end

    // Compares each logged write against the reference list
    initial begin
        memReq_t entry;
        forever begin
            @(posedge nSCLK);
            while (writeLog.size() > 0) begin
                entry = writeLog.pop_front();
                if (compared >= expected.size()) begin
                    $display("Unexpected extra memory write at address %0h", entry.addr);
                    $display("** FAIL **");
                    $fatal(1, "Extra write");
                end
                checkVal("write address", 64'(expected[compared].addr), 64'(entry.addr));
                checkVal("write data", 64'(expected[compared].data), 64'(entry.data));
                lastData = entry.data;
                compared++;
            end
        end
    end

    // dack may only rise a cycle after dreq was seen high
    always @(posedge nSCLK) begin
        if (nAS_ && dack && !dackPrev)
            checkVal("dack answers dreq", 64'h1, 64'(dreqPrev));
        dackPrev <= dack;
        dreqPrev <= dreq;
    end

    initial begin
        repeat (limitCycles) @(posedge nSCLK);
        $display("Timeout: the run did not finish within %0d cycles", limitCycles);
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        void'($urandom(32'h1f3a_989e));
        nAS_        = 1'b0;
        cpuReq      = '0;
        regReq      = 1'b0;
        dreq        = 1'b0;
        pData       = '0;
        maxMemDelay = 3;
        maxGap      = 1;
        testName    = "reset";
        repeat (2) @(negedge nSCLK);
        nAS_ = 1'b1;
        checkVal("regAck after reset", 64'h0, 64'(regAck));
        checkVal("dack after reset", 64'h0, 64'(dack));
        checkVal("memReq after reset", 64'h0, 64'(memReq));
        checkVal("int after reset", 64'h0, 64'(intLine));

        testName = "register readback";
        regAccess(1'b1, regAddrSel, 32'h1234_5678, rd);
        regAccess(1'b0, regAddrSel, '0, rd);
        checkVal("address register", 64'h1234_5678, 64'(rd));
        regAccess(1'b1, regCountSel, 32'h0000_beef, rd);
        regAccess(1'b0, regCountSel, '0, rd);
        checkVal("count register", 64'h0000_beef, 64'(rd));

        runTransfer("sixteen bytes", 32'h100, 16, 1'b1);
        runTransfer("seven bytes", 32'h200, 7, 1'b0);
        checkVal("low byte of last word", 64'h0, 64'(lastData[7:0]));

        maxMemDelay = 25;  // Slow memory fills the FIFO
        maxGap      = 3;
        runTransfer("back-pressure", 32'h1000, 40, 1'b1);

        $display("** PASS **");
        $finish;
    end

endmodule

/* filelist.f */
hdl/dmacPkg.sv
hdl/dmacRegisters.sv
hdl/periphPort.sv
hdl/wordFifo.sv
hdl/busMaster.sv
hdl/sdmacTop.sv
sim/sdmacTb.sv

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module sdmacTb -f filelist.f -o simv

# A failing run exits nonzero, the log decides the result
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation finished without failure"
